// File: build.f
cpu_pkg.sv
regfile_if.sv
alu.sv
register_file.sv
program_counter.sv
cpu_sequencer.sv
cpu_top.sv
tb_mem_model.sv
tb_cpu.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_cpu
LINT_TOP   ?= cpu_top
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT  ?= Result: PASSED

SOURCES   := $(shell cat $(FILELIST))
RTL_FILES := $(filter-out tb_%,$(SOURCES))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_cpu.sv
`default_nettype none

module tb_cpu;

    import cpu_pkg::*;

    localparam addr_t MAIN_VECTOR  = 32'h0000_0000;
    localparam addr_t ALT_VECTOR   = 32'h0000_0040;
    localparam int    NUM_TESTS    = 6;
    localparam int    HALT_LIMIT   = 200 * 12;
    localparam int    CLOCK_PERIOD = 40;
    localparam int    RESET_CYCLES = 10;

    logic  clock;
    logic  rst_n;
    logic  random_delay;
    logic  mem_req;
    logic  mem_write;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_ack;
    logic  halted;
    logic  alt_req;
    addr_t alt_addr;

    word_t program_words[$];
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    seen_protocol;

    cpu_top #(.RESET_VECTOR (MAIN_VECTOR)) UUT (
        .clock (clock), .rst_n (rst_n), .mem_req (mem_req), .mem_write (mem_write),
        .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_rdata (mem_rdata),
        .mem_ack (mem_ack), .halted (halted)
    );

    // second core only shows where a non-zero vector starts fetching
    cpu_top #(.RESET_VECTOR (ALT_VECTOR)) uut_vector (
        .clock (clock), .rst_n (rst_n), .mem_req (alt_req), .mem_write (),
        .mem_addr (alt_addr), .mem_wdata (), .mem_rdata (32'h0),
        .mem_ack (1'b0), .halted ()
    );

    tb_mem_model mem_model (
        .clock (clock), .random_delay (random_delay), .mem_req (mem_req),
        .mem_write (mem_write), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata), .mem_ack (mem_ack)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial
    begin
        #(NUM_TESTS * 200 * 12 * CLOCK_PERIOD);
        $display("watchdog: the run did not finish within its time limit");
        $display("Result: FAILED");
        $finish;
    end

    // unused words decode as halt, with the address in the immediate
    function automatic word_t fill_word(int addr);
        return {addr[15:0], 10'd0, OP_HALT};
    endfunction

    function automatic word_t encode(opcode_t op, reg_idx_t dest, reg_idx_t src_a,
                                     reg_idx_t src_b, logic high, logic [15:0] imm);
        return {imm, high, dest, src_b, src_a, op};
    endfunction

    function automatic word_t peek(addr_t addr);
        return mem_model.mem[addr[7:0]];
    endfunction

    task automatic emit(opcode_t op, reg_idx_t dest, reg_idx_t src_a, reg_idx_t src_b,
                        logic high, logic [15:0] imm);
        program_words.push_back(encode(op, dest, src_a, src_b, high, imm));
    endtask

    task automatic emit_constant(reg_idx_t dest, word_t value);
        emit(OP_LOADI, dest, 3'd0, 3'd0, 1'b0, value[15:0]);
        emit(OP_LOADI, dest, dest, 3'd0, 1'b1, value[31:16]);
    endtask

    // r0 holds the store address
    task automatic emit_store(reg_idx_t src, logic [15:0] addr);
        emit(OP_LOADI, 3'd0, 3'd0, 3'd0, 1'b0, addr);
        emit(OP_STORE, 3'd0, src, 3'd0, 1'b0, 16'h0);
    endtask

    // jump over the two words of the store that follows
    task automatic emit_skip(opcode_t op, reg_idx_t src);
        emit(op, 3'd0, src, 3'd0, 1'b0, 16'(int'(MAIN_VECTOR) + program_words.size() + 3));
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++)
            mem_model.mem[8'(i)] = fill_word(i);
        foreach (program_words[i])
            mem_model.mem[8'(int'(MAIN_VECTOR) + i)] = program_words[i];
        program_words.delete();
    endtask

    task automatic compare_word(string name, word_t expected, word_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_addr(string name, addr_t expected, addr_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic reset_cpu();
        logic req_seen;
        req_seen = 1'b0;
        @(posedge clock);
        rst_n <= 1'b0;
        // the release edge is the last one that still sees rst_n low
        repeat (RESET_CYCLES - 1)
        begin
            @(posedge clock);
            @(negedge clock);
            if (mem_req !== 1'b0 || alt_req !== 1'b0)
                req_seen = 1'b1;
        end
        if (req_seen)
            report_error("reset: mem_req was not held low while reset was asserted");
        @(posedge clock);
        rst_n <= 1'b1;
    endtask

    task automatic wait_halt(string name);
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < HALT_LIMIT)
        begin
            @(negedge clock);
            cycles++;
        end
        if (halted !== 1'b1)
            report_error($sformatf("%s: the core did not halt within %0d cycles", name,
                                   HALT_LIMIT));
    endtask

    task automatic finish_test(string name, int start);
        if (mem_model.protocol_errors != seen_protocol)
        begin
            errors += mem_model.protocol_errors - seen_protocol;
            seen_protocol = mem_model.protocol_errors;
        end
        tests_run++;
        if (errors == start)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors - start);
        end
    endtask

    task automatic test_reset();
        int start;
        int cycles;
        start = errors;
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0);
        load_program();
        reset_cpu();
        cycles = 0;
        while (mem_req !== 1'b1 && cycles < 20)
        begin
            @(negedge clock);
            cycles++;
        end
        if (mem_req !== 1'b1 || alt_req !== 1'b1)
            report_error("reset: no memory request followed the release of reset");
        compare_addr("reset", MAIN_VECTOR, mem_addr);
        compare_addr("reset nonzero vector", ALT_VECTOR, alt_addr);
        wait_halt("reset");
        finish_test("reset", start);
    endtask

    task automatic test_alu(string name);
        word_t a;
        word_t b;
        int    start;
        start = errors;
        a = 32'h1234_5678;
        b = 32'hF0F0_9ABC;
        emit_constant(3'd1, a);
        emit_constant(3'd2, b);
        emit(OP_ADD, 3'd3, 3'd1, 3'd2, 1'b0, 16'h0);
        emit(OP_SUB, 3'd4, 3'd1, 3'd2, 1'b0, 16'h0);
        emit(OP_AND, 3'd5, 3'd1, 3'd2, 1'b0, 16'h0);
        emit(OP_OR, 3'd6, 3'd1, 3'd2, 1'b0, 16'h0);
        emit(OP_XOR, 3'd7, 3'd1, 3'd2, 1'b0, 16'h0);
        for (int r = 3; r <= 7; r++)
            emit_store(3'(r), 16'(32'h80 + r - 3));
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0);
        load_program();
        reset_cpu();
        wait_halt(name);
        compare_word({name, " add"}, a + b, peek(32'h80));
        compare_word({name, " sub"}, a - b, peek(32'h81));
        compare_word({name, " and"}, a & b, peek(32'h82));
        compare_word({name, " or"}, a | b, peek(32'h83));
        compare_word({name, " xor"}, a ^ b, peek(32'h84));
        finish_test(name, start);
    endtask

    task automatic test_load_store();
        int start;
        start = errors;
        emit_constant(3'd1, 32'hCAFE_BEEF);
        emit(OP_LOADI, 3'd2, 3'd0, 3'd0, 1'b0, 16'h0090);
        emit(OP_STORE, 3'd0, 3'd1, 3'd2, 1'b0, 16'h0);
        emit(OP_LOAD, 3'd3, 3'd2, 3'd0, 1'b0, 16'h0);
        emit(OP_LOADI, 3'd4, 3'd0, 3'd0, 1'b0, 16'h0091);
        emit(OP_STORE, 3'd0, 3'd3, 3'd4, 1'b0, 16'h0);
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0);
        load_program();
        reset_cpu();
        wait_halt("load_store");
        compare_word("load_store first", 32'hCAFE_BEEF, peek(32'h90));
        compare_word("load_store copy", 32'hCAFE_BEEF, peek(32'h91));
        finish_test("load_store", start);
    endtask

    task automatic test_flags_jumps();
        int start;
        start = errors;
        emit_constant(3'd1, 32'hFFFF_FFFF);
        emit(OP_LOADI, 3'd2, 3'd0, 3'd0, 1'b0, 16'h0001);
        emit(OP_LOADI, 3'd7, 3'd0, 3'd0, 1'b0, 16'h5A5A);
        emit(OP_ADD, 3'd3, 3'd1, 3'd2, 1'b0, 16'h0);
        emit_skip(OP_JF, 3'd3);
        emit_store(3'd7, 16'h00A0);
        emit(OP_ADD, 3'd4, 3'd2, 3'd2, 1'b0, 16'h0);
        emit_skip(OP_JF, 3'd4);
        emit_store(3'd7, 16'h00A1);
        emit_skip(OP_JMP, 3'd0);
        emit_store(3'd7, 16'h00A2);
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0);
        load_program();
        reset_cpu();
        wait_halt("flags_jumps");
        compare_word("flags_jumps carry taken", fill_word('hA0), peek(32'hA0));
        compare_word("flags_jumps no carry", 32'h0000_5A5A, peek(32'hA1));
        compare_word("flags_jumps jmp", fill_word('hA2), peek(32'hA2));
        finish_test("flags_jumps", start);
    endtask

    task automatic test_halt();
        int   start;
        logic req_seen;
        logic halt_dropped;
        start = errors;
        req_seen = 1'b0;
        halt_dropped = 1'b0;
        emit(OP_LOADI, 3'd1, 3'd0, 3'd0, 1'b0, 16'h0001);
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0);
        load_program();
        reset_cpu();
        wait_halt("halt");
        repeat (50)
        begin
            @(negedge clock);
            if (mem_req !== 1'b0)
                req_seen = 1'b1;
            if (halted !== 1'b1)
                halt_dropped = 1'b1;
        end
        if (req_seen)
            report_error("halt: a memory request appeared after the core halted");
        if (halt_dropped)
            report_error("halt: halted went low before the next reset");
        finish_test("halt", start);
    endtask

    initial
    begin
        rst_n <= 1'b0;
        random_delay <= 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        seen_protocol = 0;
        test_reset();
        test_alu("alu");
        test_load_store();
        test_flags_jumps();
        @(posedge clock);
        random_delay <= 1'b1;
        test_alu("slow_memory");
        @(posedge clock);
        random_delay <= 1'b0;
        test_halt();
        $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none

module tb_mem_model (
    input  wire                 clock,
    input  wire                 random_delay,
    input  wire                 mem_req,
    input  wire                 mem_write,
    input  wire cpu_pkg::addr_t mem_addr,
    input  wire cpu_pkg::word_t mem_wdata,
    output cpu_pkg::word_t      mem_rdata,
    output logic                mem_ack
);

    import cpu_pkg::*;

    word_t mem [256];
    int    protocol_errors;

    logic  prev_req;
    logic  prev_ack;
    logic  busy;
    int    delay_left;
    logic  held_write;
    addr_t held_addr;
    word_t held_wdata;

    initial
    begin
        void'($urandom(17));
        protocol_errors = 0;
        prev_req = 1'b0;
        prev_ack = 1'b0;
        busy = 1'b0;
        delay_left = 0;
        mem_ack <= 1'b0;
        mem_rdata <= '0;
        forever
        begin
            @(posedge clock);
            // prev_ack is the ack level the core saw when it raised mem_req
            if (mem_req === 1'b1 && !prev_req && prev_ack)
            begin
                protocol_errors++;
                $display("memory model: mem_req rose while mem_ack was still high");
            end
            if (mem_req === 1'b1 && prev_req && (mem_write !== held_write
                    || mem_addr !== held_addr || mem_wdata !== held_wdata))
            begin
                protocol_errors++;
                $display("memory model: a bus output changed while mem_req was high");
            end
            if (mem_req === 1'b1 && !prev_req)
            begin
                held_write = mem_write;
                held_addr  = mem_addr;
                held_wdata = mem_wdata;
            end
            prev_req = (mem_req === 1'b1);
            prev_ack = mem_ack;
            if (mem_ack)
            begin
                if (mem_req !== 1'b1)
                    mem_ack <= 1'b0;
            end
            else if (mem_req === 1'b1)
            begin
                if (!busy)
                begin
                    busy = 1'b1;
                    delay_left = random_delay ? int'($urandom % 4) : 0;
                end
                if (delay_left == 0)
                begin
                    busy = 1'b0;
                    if (mem_write)
                        mem[mem_addr[7:0]] = mem_wdata;
                    else
                        mem_rdata <= mem[mem_addr[7:0]];
                    mem_ack <= 1'b1;
                end
                else
                    delay_left--;
            end
        end
    end

endmodule

`default_nettype wire

// File: cpu_top.sv
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::addr_t RESET_VECTOR = '0
) (
    input  wire                 clock,
    input  wire                 rst_n,
    output logic                mem_req,
    output logic                mem_write,
    output cpu_pkg::addr_t      mem_addr,
    output cpu_pkg::word_t      mem_wdata,
    input  wire cpu_pkg::word_t mem_rdata,
    input  wire                 mem_ack,
    output logic                halted
);

    import cpu_pkg::*;

    addr_t       pc;
    logic        pc_advance;
    logic        pc_load;
    addr_t       pc_target;
    opcode_t     alu_op;
    word_t       alu_a;
    word_t       alu_b;
    logic [15:0] alu_imm;
    logic        alu_high;
    word_t       alu_result;
    logic        alu_flag;

    regfile_if rf_bus ();

    cpu_sequencer u_sequencer (
        .clock      (clock),
        .rst_n      (rst_n),
        .rf         (rf_bus.client),
        .pc         (pc),
        .pc_advance (pc_advance),
        .pc_load    (pc_load),
        .pc_target  (pc_target),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_imm    (alu_imm),
        .alu_high   (alu_high),
        .alu_result (alu_result),
        .alu_flag   (alu_flag),
        .mem_req    (mem_req),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack),
        .halted     (halted)
    );

    program_counter #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_pc (
        .clock   (clock),
        .rst_n   (rst_n),
        .advance (pc_advance),
        .load    (pc_load),
        .target  (pc_target),
        .pc      (pc)
    );

    register_file u_regfile (
        .clock (clock),
        .rst_n (rst_n),
        .rf    (rf_bus.file)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .imm    (alu_imm),
        .high   (alu_high),
        .result (alu_result),
        .flag   (alu_flag)
    );

endmodule

`default_nettype wire

// File: cpu_sequencer.sv
`default_nettype none

module cpu_sequencer (
    input  wire                     clock,
    input  wire                     rst_n,
    regfile_if.client               rf,
    input  wire cpu_pkg::addr_t     pc,
    output logic                    pc_advance,
    output logic                    pc_load,
    output cpu_pkg::addr_t          pc_target,
    output cpu_pkg::opcode_t        alu_op,
    output cpu_pkg::word_t          alu_a,
    output cpu_pkg::word_t          alu_b,
    output logic [15:0]             alu_imm,
    output logic                    alu_high,
    input  wire cpu_pkg::word_t     alu_result,
    input  wire                     alu_flag,
    output logic                    mem_req,
    output logic                    mem_write,
    output cpu_pkg::addr_t          mem_addr,
    output cpu_pkg::word_t          mem_wdata,
    input  wire cpu_pkg::word_t     mem_rdata,
    input  wire                     mem_ack,
    output logic                    halted
);

    import cpu_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH_REQ,
        S_FETCH_REL,
        S_EXEC,
        S_MEM_REQ,
        S_MEM_REL,
        S_WB,
        S_HALT
    } state_t;

    state_t state;
    instr_t ir;
    word_t  load_data;
    logic   writes_alu;
    logic   jump_taken;

    assign writes_alu = ir.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LOADI};
    assign jump_taken = (ir.opcode == OP_JMP) || (ir.opcode == OP_JF && rf.rflag_a);

    assign rf.raddr_a = ir.src_a;
    assign rf.raddr_b = ir.src_b;
    assign rf.waddr   = ir.dest;
    assign rf.we      = (state == S_EXEC && writes_alu) || (state == S_WB);
    // loaded words always come back with the flag clear
    assign rf.wdata   = (state == S_WB) ? load_data : alu_result;
    assign rf.wflag   = (state == S_WB) ? 1'b0 : alu_flag;

    assign alu_op   = ir.opcode;
    assign alu_a    = rf.rdata_a;
    assign alu_b    = rf.rdata_b;
    assign alu_imm  = ir.imm;
    assign alu_high = ir.high;

    assign pc_advance = (state == S_EXEC) && (ir.opcode != OP_HALT);
    assign pc_load    = (state == S_EXEC) && jump_taken;
    assign pc_target  = addr_t'(ir.imm);
    assign halted     = (state == S_HALT);

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state     <= S_FETCH_REQ;
            mem_req   <= 1'b0;
            mem_write <= 1'b0;
        end
        else
        begin
            case (state)
                S_FETCH_REQ:
                begin
                    if (!mem_req)
                    begin
                        mem_req   <= 1'b1;
                        mem_write <= 1'b0;
                        mem_addr  <= pc;
                    end
                    else if (mem_ack)
                    begin
                        ir      <= instr_t'(mem_rdata);
                        mem_req <= 1'b0;
                        state   <= S_FETCH_REL;
                    end
                end
                // wait for the memory to finish the handshake
                S_FETCH_REL:
                begin
                    if (!mem_ack)
                        state <= S_EXEC;
                end
                S_EXEC:
                begin
                    case (ir.opcode)
                        OP_LOAD, OP_STORE: state <= S_MEM_REQ;
                        OP_HALT:           state <= S_HALT;
                        default:           state <= S_FETCH_REQ;
                    endcase
                end
                S_MEM_REQ:
                begin
                    if (!mem_req)
                    begin
                        // store: data from A to the address in B, load: address in A
                        mem_req   <= 1'b1;
                        mem_write <= (ir.opcode == OP_STORE);
                        mem_addr  <= (ir.opcode == OP_STORE) ? addr_t'(rf.rdata_b)
                                                             : addr_t'(rf.rdata_a);
                        mem_wdata <= rf.rdata_a;
                    end
                    else if (mem_ack)
                    begin
                        load_data <= mem_rdata;
                        mem_req   <= 1'b0;
                        state     <= S_MEM_REL;
                    end
                end
                S_MEM_REL:
                begin
                    if (!mem_ack)
                    begin
                        mem_write <= 1'b0;
                        state     <= mem_write ? S_FETCH_REQ : S_WB;
                    end
                end
                S_WB:
                    state <= S_FETCH_REQ;
                default:
                    state <= S_HALT;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: program_counter.sv
`default_nettype none

module program_counter #(
    parameter cpu_pkg::addr_t RESET_VECTOR = '0
) (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 advance,
    input  wire                 load,
    input  wire cpu_pkg::addr_t target,
    output cpu_pkg::addr_t      pc
);

    // a jump target takes priority over the increment
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            pc <= RESET_VECTOR;
        end
        else if (load)
        begin
            pc <= target;
        end
        else if (advance)
        begin
            pc <= pc + 32'd1;
        end
    end

endmodule

`default_nettype wire

// File: register_file.sv
`default_nettype none

module register_file (
    input  wire     clock,
    input  wire     rst_n,
    regfile_if.file rf
);

    import cpu_pkg::*;

    word_t               regs [NUM_REGS];
    logic [NUM_REGS-1:0] flags;

    // value and flag are always written together
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (rf.we)
        begin
            regs[rf.waddr]  <= rf.wdata;
            flags[rf.waddr] <= rf.wflag;
        end
    end

    // reads are combinational
    assign rf.rdata_a = regs[rf.raddr_a];
    assign rf.rdata_b = regs[rf.raddr_b];
    assign rf.rflag_a = flags[rf.raddr_a];

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
    input  wire cpu_pkg::opcode_t op,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    input  wire [15:0]            imm,
    input  wire                   high,
    output cpu_pkg::word_t        result,
    output logic                  flag
);

    import cpu_pkg::*;

    logic [32:0] sum;
    logic [32:0] diff;
    word_t       logic_out;

    // bit 32 carries the carry out or the borrow
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb
    begin
        case (op)
            OP_AND:  logic_out = a & b;
            OP_OR:   logic_out = a | b;
            default: logic_out = a ^ b;
        endcase
    end

    always_comb
    begin
        result = '0;
        flag   = 1'b0;
        case (op)
            OP_ADD:
            begin
                result = sum[31:0];
                flag   = sum[32];
            end
            OP_SUB:
            begin
                result = diff[31:0];
                flag   = diff[32];
            end
            OP_AND, OP_OR, OP_XOR:
            begin
                result = logic_out;
                flag   = (logic_out == '0);
            end
            OP_LOADI:
            begin
                // high half keeps the low half of a so constants build in two steps
                result = high ? {imm, a[15:0]} : {16'h0000, imm};
                flag   = 1'b0;
            end
            default:
            begin
                result = '0;
                flag   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: regfile_if.sv
`default_nettype none

interface regfile_if;

    import cpu_pkg::*;

    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    reg_idx_t waddr;
    word_t    wdata;
    logic     wflag;
    logic     we;
    word_t    rdata_a;
    word_t    rdata_b;
    logic     rflag_a;

    modport client (
        output raddr_a,
        output raddr_b,
        output waddr,
        output wdata,
        output wflag,
        output we,
        input  rdata_a,
        input  rdata_b,
        input  rflag_a
    );

    modport file (
        input  raddr_a,
        input  raddr_b,
        input  waddr,
        input  wdata,
        input  wflag,
        input  we,
        output rdata_a,
        output rdata_b,
        output rflag_a
    );

endinterface

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // eight general registers, each with its own flag
    localparam int NUM_REGS = 8;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [2:0]  reg_idx_t;

    typedef enum logic [5:0] {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_LOADI = 6'd6,
        OP_STORE = 6'd7,
        OP_LOAD  = 6'd8,
        OP_JMP   = 6'd10,
        OP_JF    = 6'd11,
        OP_HALT  = 6'd63
    } opcode_t;

    // first member lands in the top bits
    typedef struct packed {
        logic [15:0] imm;
        logic        high;
        reg_idx_t    dest;
        reg_idx_t    src_b;
        reg_idx_t    src_a;
        opcode_t     opcode;
    } instr_t;

endpackage

`default_nettype wire
